// ==== logic/vbus_pkg.sv ====
//////////////////////////////////////////////////
// vector bus shared definitions
// word types, widths and vector CSR addresses
//////////////////////////////////////////////////
package vbus_pkg;

    localparam int unsigned XLen = 32;  // scalar word width

    typedef logic [31:0]     addr_t;
    typedef logic [XLen-1:0] word_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [1:0]      vxrm_t;  // fixed-point rounding mode

    //////////////////////////////////////////////////
    // vector CSR addresses

    // user read/write
    localparam csr_addr_t CsrVstart = 12'h008;
    localparam csr_addr_t CsrVxsat  = 12'h009;
    localparam csr_addr_t CsrVxrm   = 12'h00A;
    localparam csr_addr_t CsrVcsr   = 12'h00F;  // alias of vxrm and vxsat

    // user read only
    localparam csr_addr_t CsrVl     = 12'hC20;
    localparam csr_addr_t CsrVtype  = 12'hC21;
    localparam csr_addr_t CsrVlenb  = 12'hC22;

endpackage

// ==== logic/vbus_csr_bank.sv ====
//////////////////////////////////////////////////
// vector CSR bank
// vstart, vxsat and vxrm with the vcsr alias
//////////////////////////////////////////////////
module vbus_csr_bank #(
    parameter int unsigned VregW = 128  // vector register width in bits
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  vbus_pkg::csr_addr_t csr_addr_i,
    input  logic                csr_we_i,
    input  vbus_pkg::word_t     csr_wdata_i,
    output vbus_pkg::word_t     csr_rdata_o,

    input  vbus_pkg::word_t     vl_i,
    input  vbus_pkg::word_t     vtype_i,

    output vbus_pkg::word_t     vstart_o,
    output logic                vxsat_o,
    output vbus_pkg::vxrm_t     vxrm_o
);
    import vbus_pkg::*;

    word_t vstart_q;
    logic  vxsat_q;
    vxrm_t vxrm_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vstart_q <= '0;
            vxsat_q  <= 1'b0;
            vxrm_q   <= '0;
        end else if (csr_we_i) begin
            unique case (csr_addr_i)
                CsrVstart: vstart_q <= csr_wdata_i;
                CsrVxsat:  vxsat_q  <= csr_wdata_i[0];
                CsrVxrm:   vxrm_q   <= csr_wdata_i[1:0];
                CsrVcsr: begin  // both fields at once
                    vxrm_q  <= csr_wdata_i[2:1];
                    vxsat_q <= csr_wdata_i[0];
                end
                default: ;  // read-only or unknown
            endcase
        end
    end

    always_comb begin
        unique case (csr_addr_i)
            CsrVstart: csr_rdata_o = vstart_q;
            CsrVxsat:  csr_rdata_o = word_t'(vxsat_q);
            CsrVxrm:   csr_rdata_o = word_t'(vxrm_q);
            CsrVcsr:   csr_rdata_o = word_t'({vxrm_q, vxsat_q});
            CsrVl:     csr_rdata_o = vl_i;
            CsrVtype:  csr_rdata_o = vtype_i;
            CsrVlenb:  csr_rdata_o = word_t'(VregW / 8);
            default:   csr_rdata_o = '0;
        endcase
    end

    assign vstart_o = vstart_q;
    assign vxsat_o  = vxsat_q;
    assign vxrm_o   = vxrm_q;

endmodule

// ==== logic/vbus_data_arbiter.sv ====
//////////////////////////////////////////////////
// data arbiter, vector unit over scalar core
// steers scalar accesses into the right bus lane
//////////////////////////////////////////////////
module vbus_data_arbiter #(
    parameter int unsigned MemW = 64  // bus width in bits
) (
    input  logic              clk_i,
    input  logic              rst_ni,

    // scalar core
    input  logic              sdata_req_i,
    input  vbus_pkg::addr_t   sdata_addr_i,
    input  logic              sdata_we_i,
    input  logic [3:0]        sdata_be_i,
    input  vbus_pkg::word_t   sdata_wdata_i,
    output logic              sdata_gnt_o,
    output logic              sdata_rvalid_o,
    output logic              sdata_err_o,
    output vbus_pkg::word_t   sdata_rdata_o,

    // vector unit
    input  logic              vdata_req_i,
    input  vbus_pkg::addr_t   vdata_addr_i,
    input  logic              vdata_we_i,
    input  logic [MemW/8-1:0] vdata_be_i,
    input  logic [MemW-1:0]   vdata_wdata_i,
    input  logic              pending_load_i,
    input  logic              pending_store_i,
    output logic              vdata_gnt_o,
    output logic              vdata_rvalid_o,
    output logic              vdata_err_o,
    output logic [MemW-1:0]   vdata_rdata_o,

    // towards memory arbiter
    output logic              dreq_o,
    output vbus_pkg::addr_t   daddr_o,
    output logic              dwe_o,
    output logic [MemW/8-1:0] dbe_o,
    output logic [MemW-1:0]   dwdata_o,
    input  logic              dgnt_i,
    input  logic              drvalid_i,
    input  logic              derr_i,
    input  logic [MemW-1:0]   drdata_i
);
    import vbus_pkg::*;

    localparam int unsigned BeW  = MemW / 8;
    localparam int unsigned OffW = $clog2(BeW);

    logic            sdata_hold;
    logic [OffW-1:0] s_off;    // byte offset of the scalar word lane
    logic [OffW-1:0] s_off_q;  // lane of the outstanding scalar access
    logic            sdata_waiting_q;
    logic            vdata_waiting_q;

    // scalar waits while the vector side owns or may alias the bus
    assign sdata_hold = vdata_req_i | pending_store_i | (pending_load_i & sdata_we_i);
    assign s_off      = sdata_addr_i[OffW-1:0] & ~OffW'(3);

    //////////////////////////////////////////////////
    // request mux

    always_comb begin
        if (vdata_req_i) begin
            daddr_o  = vdata_addr_i;
            dwe_o    = vdata_we_i;
            dbe_o    = vdata_be_i;
            dwdata_o = vdata_wdata_i;
        end else begin
            daddr_o  = sdata_addr_i;
            dwe_o    = sdata_we_i;
            dbe_o    = BeW'(sdata_be_i) << s_off;
            dwdata_o = {(MemW / XLen){sdata_wdata_i}};  // word copied into every lane
        end
    end

    assign dreq_o      = vdata_req_i | (sdata_req_i & ~sdata_hold);
    assign sdata_gnt_o = dgnt_i & sdata_req_i & ~sdata_hold;
    assign vdata_gnt_o = dgnt_i & vdata_req_i;

    //////////////////////////////////////////////////
    // response routing

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sdata_waiting_q <= 1'b0;
            vdata_waiting_q <= 1'b0;
        end else begin
            if (sdata_gnt_o) begin
                sdata_waiting_q <= 1'b1;
            end else if (sdata_rvalid_o) begin
                sdata_waiting_q <= 1'b0;
            end
            if (vdata_gnt_o) begin
                vdata_waiting_q <= ~vdata_we_i;  // vector stores get no rvalid
            end else if (vdata_rvalid_o) begin
                vdata_waiting_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sdata_gnt_o) begin
            s_off_q <= s_off;
        end
    end

    assign sdata_rvalid_o = sdata_waiting_q & drvalid_i;
    assign vdata_rvalid_o = vdata_waiting_q & drvalid_i;
    assign sdata_err_o    = derr_i;
    assign vdata_err_o    = derr_i;
    assign sdata_rdata_o  = drdata_i[s_off_q*8 +: XLen];
    assign vdata_rdata_o  = drdata_i;

endmodule

// ==== logic/vbus_mem_arbiter.sv ====
//////////////////////////////////////////////////
// memory arbiter, data over instruction fetch
// in-order source queue routes each response
//////////////////////////////////////////////////
module vbus_mem_arbiter #(
    parameter int unsigned MemW          = 64,  // bus width in bits
    parameter int unsigned SrcQueueDepth = 32   // max outstanding requests
) (
    input  logic              clk_i,
    input  logic              rst_ni,

    // instruction fetch
    input  logic              instr_req_i,
    input  vbus_pkg::addr_t   instr_addr_i,
    output logic              instr_gnt_o,
    output logic              instr_rvalid_o,
    output logic              instr_err_o,
    output vbus_pkg::word_t   instr_rdata_o,

    // data
    input  logic              dreq_i,
    input  vbus_pkg::addr_t   daddr_i,
    input  logic              dwe_i,
    input  logic [MemW/8-1:0] dbe_i,
    input  logic [MemW-1:0]   dwdata_i,
    output logic              dgnt_o,
    output logic              drvalid_o,
    output logic              derr_o,
    output logic [MemW-1:0]   drdata_o,

    // external memory
    output logic              mem_req_o,
    output vbus_pkg::addr_t   mem_addr_o,
    output logic              mem_we_o,
    output logic [MemW/8-1:0] mem_be_o,
    output logic [MemW-1:0]   mem_wdata_o,
    input  logic              mem_rvalid_i,
    input  logic              mem_err_i,
    input  logic [MemW-1:0]   mem_rdata_i
);
    import vbus_pkg::*;

    localparam int unsigned OffW = $clog2(MemW / 8);
    localparam int unsigned CntW = $clog2(SrcQueueDepth + 1);

    logic            push;
    logic            pop;
    logic [CntW-1:0] req_count_q;
    logic [CntW-1:0] wr_idx;
    logic [OffW-1:0] instr_off;
    logic            src_data_q  [SrcQueueDepth];  // 1 for data, 0 for fetch
    logic [OffW-1:0] instr_off_q [SrcQueueDepth];

    // data always wins
    assign dgnt_o      = dreq_i;
    assign instr_gnt_o = instr_req_i & ~dreq_i;

    always_comb begin
        mem_req_o   = instr_req_i | dreq_i;
        mem_addr_o  = dreq_i ? daddr_i : instr_addr_i;
        mem_we_o    = dreq_i & dwe_i;
        mem_be_o    = dreq_i ? dbe_i : '1;
        mem_wdata_o = dwdata_i;
    end

    //////////////////////////////////////////////////
    // response source queue

    assign push      = instr_gnt_o | dgnt_o;
    assign pop       = mem_rvalid_i;
    assign wr_idx    = pop ? req_count_q - 1'b1 : req_count_q;  // head shifts on pop
    assign instr_off = instr_addr_i[OffW-1:0] & ~OffW'(3);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_count_q <= '0;
        end else if (push && !pop) begin
            req_count_q <= req_count_q + 1'b1;
        end else if (pop && !push) begin
            req_count_q <= req_count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            for (int i = 0; i < SrcQueueDepth - 1; i++) begin
                src_data_q[i]  <= src_data_q[i+1];
                instr_off_q[i] <= instr_off_q[i+1];
            end
        end
        if (push) begin
            for (int i = 0; i < SrcQueueDepth; i++) begin
                if (CntW'(i) == wr_idx) begin
                    src_data_q[i]  <= dgnt_o;
                    instr_off_q[i] <= instr_off;
                end
            end
        end
    end

    assign instr_rvalid_o = mem_rvalid_i & ~src_data_q[0];
    assign drvalid_o      = mem_rvalid_i &  src_data_q[0];
    assign instr_err_o    = mem_err_i;
    assign derr_o         = mem_err_i;
    assign instr_rdata_o  = mem_rdata_i[instr_off_q[0]*8 +: XLen];  // fetch lane
    assign drdata_o       = mem_rdata_i;

endmodule

// ==== logic/vbus_top.sv ====
//////////////////////////////////////////////////
// vector bus top level
// CSR bank, data arbiter and memory arbiter
//////////////////////////////////////////////////
module vbus_top #(
    parameter int unsigned MemW          = 64,
    parameter int unsigned VregW         = 128,
    parameter int unsigned SrcQueueDepth = 32
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    // instruction fetch
    input  logic                instr_req_i,
    input  vbus_pkg::addr_t     instr_addr_i,
    output logic                instr_gnt_o,
    output logic                instr_rvalid_o,
    output logic                instr_err_o,
    output vbus_pkg::word_t     instr_rdata_o,

    // scalar data
    input  logic                sdata_req_i,
    input  vbus_pkg::addr_t     sdata_addr_i,
    input  logic                sdata_we_i,
    input  logic [3:0]          sdata_be_i,
    input  vbus_pkg::word_t     sdata_wdata_i,
    output logic                sdata_gnt_o,
    output logic                sdata_rvalid_o,
    output logic                sdata_err_o,
    output vbus_pkg::word_t     sdata_rdata_o,

    // vector data
    input  logic                vdata_req_i,
    input  vbus_pkg::addr_t     vdata_addr_i,
    input  logic                vdata_we_i,
    input  logic [MemW/8-1:0]   vdata_be_i,
    input  logic [MemW-1:0]     vdata_wdata_i,
    input  logic                pending_load_i,
    input  logic                pending_store_i,
    output logic                vdata_gnt_o,
    output logic                vdata_rvalid_o,
    output logic                vdata_err_o,
    output logic [MemW-1:0]     vdata_rdata_o,

    // external memory
    output logic                mem_req_o,
    output vbus_pkg::addr_t     mem_addr_o,
    output logic                mem_we_o,
    output logic [MemW/8-1:0]   mem_be_o,
    output logic [MemW-1:0]     mem_wdata_o,
    input  logic                mem_rvalid_i,
    input  logic                mem_err_i,
    input  logic [MemW-1:0]     mem_rdata_i,

    // vector CSRs
    input  vbus_pkg::csr_addr_t csr_addr_i,
    input  logic                csr_we_i,
    input  vbus_pkg::word_t     csr_wdata_i,
    output vbus_pkg::word_t     csr_rdata_o,
    input  vbus_pkg::word_t     vl_i,
    input  vbus_pkg::word_t     vtype_i,
    output vbus_pkg::word_t     vstart_o,
    output logic                vxsat_o,
    output vbus_pkg::vxrm_t     vxrm_o
);
    import vbus_pkg::*;

    if ((MemW & (MemW - 1)) != 0 || MemW < 32) begin : g_memw_check
        $fatal(1, "MemW must be a power of two and at least 32, got %0d", MemW);
    end

    // internal data port
    logic              dreq;
    addr_t             daddr;
    logic              dwe;
    logic [MemW/8-1:0] dbe;
    logic [MemW-1:0]   dwdata;
    logic              dgnt;
    logic              drvalid;
    logic              derr;
    logic [MemW-1:0]   drdata;

    vbus_csr_bank #(
        .VregW ( VregW )
    ) u_csr_bank (
        .*
    );

    vbus_data_arbiter #(
        .MemW      ( MemW    )
    ) u_data_arbiter (
        .dreq_o    ( dreq    ),
        .daddr_o   ( daddr   ),
        .dwe_o     ( dwe     ),
        .dbe_o     ( dbe     ),
        .dwdata_o  ( dwdata  ),
        .dgnt_i    ( dgnt    ),
        .drvalid_i ( drvalid ),
        .derr_i    ( derr    ),
        .drdata_i  ( drdata  ),
        .*
    );

    vbus_mem_arbiter #(
        .MemW          ( MemW          ),
        .SrcQueueDepth ( SrcQueueDepth )
    ) u_mem_arbiter (
        .dreq_i        ( dreq          ),
        .daddr_i       ( daddr         ),
        .dwe_i         ( dwe           ),
        .dbe_i         ( dbe           ),
        .dwdata_i      ( dwdata        ),
        .dgnt_o        ( dgnt          ),
        .drvalid_o     ( drvalid       ),
        .derr_o        ( derr          ),
        .drdata_o      ( drdata        ),
        .*
    );

endmodule

// ==== testbench/vbus_assert.sv ====
//////////////////////////////////////////////////
// protocol assertions for the memory arbiter
//////////////////////////////////////////////////
module vbus_assert #(
    parameter int unsigned SrcQueueDepth = 32
) (
    input logic                                 clk_i,
    input logic                                 rst_ni,
    input logic                                 instr_gnt_i,
    input logic                                 dgnt_i,
    input logic                                 mem_rvalid_i,
    input logic [$clog2(SrcQueueDepth + 1)-1:0] req_count_i
);

    // one owner of the bus per cycle
    grant_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(instr_gnt_i && dgnt_i))
        else $error("instruction fetch and data granted in the same cycle");

    queue_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        32'(req_count_i) <= SrcQueueDepth)
        else $error("source queue count above its depth");

    no_orphan_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> req_count_i != '0)
        else $error("memory response with an empty source queue");

endmodule

bind vbus_mem_arbiter vbus_assert #(
    .SrcQueueDepth ( SrcQueueDepth )
) u_assert (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .instr_gnt_i   ( instr_gnt_o   ),
    .dgnt_i        ( dgnt_o        ),
    .mem_rvalid_i  ( mem_rvalid_i  ),
    .req_count_i   ( req_count_q   )
);

// ==== testbench/tb_vbus_top.sv ====
//////////////////////////////////////////////////
// testbench for the vector bus top level
// memory model, stimulus table and checks
//////////////////////////////////////////////////
module tb_vbus_top;
    import vbus_pkg::*;

    localparam int unsigned MemW     = 64;
    localparam int unsigned VregW    = 128;
    localparam int          MaxWait  = 12;  // cycles for one handshake
    localparam int          DriveDly = 2;

    // row kinds
    localparam int KCsrRd  = 0;
    localparam int KCsrWr  = 1;
    localparam int KScalar = 2;
    localparam int KVector = 3;
    localparam int KMix    = 4;

    // flags for await_flag
    localparam int FSdataGnt   = 0;
    localparam int FSdataValid = 1;
    localparam int FVdataValid = 2;
    localparam int FMemValid   = 3;

    typedef struct packed {
        int                kind;
        addr_t             addr;
        logic              we;
        word_t             wdata;
        logic [MemW/8-1:0] be;
        logic              pload;
        logic              pstore;
        word_t             exp;
        logic [MemW/8-1:0] exp_be;
    } row_t;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic instr_req_i, instr_gnt_o, instr_rvalid_o, instr_err_o;
    addr_t instr_addr_i;
    word_t instr_rdata_o;
    logic sdata_req_i, sdata_we_i, sdata_gnt_o, sdata_rvalid_o, sdata_err_o;
    addr_t sdata_addr_i;
    logic [3:0] sdata_be_i;
    word_t sdata_wdata_i, sdata_rdata_o;
    logic vdata_req_i, vdata_we_i, pending_load_i, pending_store_i;
    logic vdata_gnt_o, vdata_rvalid_o, vdata_err_o;
    addr_t vdata_addr_i;
    logic [MemW/8-1:0] vdata_be_i, mem_be_o;
    logic [MemW-1:0] vdata_wdata_i, vdata_rdata_o, mem_wdata_o, mem_rdata_i;
    logic mem_req_o, mem_we_o, mem_rvalid_i, mem_err_i;
    addr_t mem_addr_o;
    csr_addr_t csr_addr_i;
    logic csr_we_i, vxsat_o;
    word_t csr_wdata_i, csr_rdata_o, vl_i, vtype_i, vstart_o;
    vxrm_t vxrm_o;

    row_t rows[$];
    int n_checks = 0;
    int n_errors = 0;

    vbus_top #(
        .MemW  ( MemW  ),
        .VregW ( VregW )
    ) u_dut (
        .*
    );

    always #10 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // external memory, in-order answers after 1 to 3 cycles

    addr_t       pend_addr[$];
    int unsigned pend_due[$];
    int unsigned cycle_cnt = 0;
    int unsigned last_due  = 0;
    int unsigned due;

    function automatic logic [MemW-1:0] mem_line(addr_t addr);
        logic [MemW-1:0] line;
        addr_t           base;
        base = addr & ~addr_t'(MemW / 8 - 1);
        for (int i = 0; i < MemW / 32; i++) begin
            line[i*32 +: 32] = 32'hA500_0000 + base + addr_t'(4 * i);  // lane byte address
        end
        return line;
    endfunction

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (rst_ni && mem_req_o) begin
            due = cycle_cnt + $urandom_range(1, 3);
            if (due <= last_due) begin
                due = last_due + 1;  // keep answers in order
            end
            last_due = due;
            pend_addr.push_back(mem_addr_o);
            pend_due.push_back(due);
        end
        #DriveDly;
        if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
            mem_rvalid_i = 1'b1;
            mem_err_i    = pend_addr[0][4];  // odd 16-byte blocks answer with a bus error
            mem_rdata_i  = mem_line(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end else begin
            mem_rvalid_i = 1'b0;
            mem_err_i    = 1'b0;
            mem_rdata_i  = '0;
        end
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic compare_value(string name, logic [MemW-1:0] got, logic [MemW-1:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic require(logic cond, string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("failure at %0t: %s", $time, what);
        end
    endtask

    function automatic logic flag(int id);
        case (id)
            FSdataGnt:   return sdata_gnt_o;
            FSdataValid: return sdata_rvalid_o;
            FVdataValid: return vdata_rvalid_o;
            default:     return mem_rvalid_i;
        endcase
    endfunction

    task automatic drive_step();
        @(posedge clk_i);
        #DriveDly;
    endtask

    // called at a falling edge, polls one flag per cycle
    task automatic await_flag(int id, string what);
        int n;
        n = 0;
        while (!flag(id) && n < MaxWait) begin
            @(negedge clk_i);
            n++;
        end
        require(flag(id), {what, " never arrived"});
    endtask

    task automatic csr_row(int kind, csr_addr_t addr, word_t value);
        rows.push_back(row_t'{kind, addr_t'(addr), 1'b0, value, '0, 1'b0, 1'b0, value, '0});
    endtask

    task automatic data_row(int kind, addr_t addr, logic we, word_t wdata, logic [7:0] be,
                            logic pload, logic pstore, word_t exp, logic [7:0] exp_be);
        rows.push_back(row_t'{kind, addr, we, wdata, be, pload, pstore, exp, exp_be});
    endtask

    // bus errors reach both requesters unchanged
    always @(negedge clk_i) begin
        if (rst_ni) begin
            compare_value("instr_err_o", MemW'(instr_err_o), MemW'(mem_err_i));
            compare_value("sdata_err_o", MemW'(sdata_err_o), MemW'(mem_err_i));
            compare_value("vdata_err_o", MemW'(vdata_err_o), MemW'(mem_err_i));
        end
    end

    //////////////////////////////////////////////////
    // row handlers

    task automatic scalar_access(row_t r);
        sdata_req_i     = 1'b1;
        sdata_addr_i    = r.addr;
        sdata_we_i      = r.we;
        sdata_be_i      = r.be[3:0];
        sdata_wdata_i   = r.wdata;
        pending_load_i  = r.pload;
        pending_store_i = r.pstore;
        if (r.pload || r.pstore) begin
            repeat (3) begin
                @(negedge clk_i);
                require(!sdata_gnt_o && !mem_req_o, "held scalar access reached the bus");
            end
            drive_step();
            pending_load_i  = 1'b0;
            pending_store_i = 1'b0;
        end
        @(negedge clk_i);
        await_flag(FSdataGnt, "scalar grant");
        compare_value("mem_we_o", MemW'(mem_we_o), MemW'(r.we));
        if (r.we) begin
            compare_value("mem_be_o", MemW'(mem_be_o), MemW'(r.exp_be));
            compare_value("mem_wdata_o", mem_wdata_o, {(MemW / 32){r.wdata}});
        end
        drive_step();
        sdata_req_i = 1'b0;
        @(negedge clk_i);
        await_flag(FSdataValid, "scalar response");
        if (!r.we) begin
            compare_value("sdata_rdata_o", MemW'(sdata_rdata_o), MemW'(r.exp));
        end
        drive_step();
    endtask

    task automatic vector_access(row_t r);
        vdata_req_i   = 1'b1;
        vdata_addr_i  = r.addr;
        vdata_we_i    = r.we;
        vdata_be_i    = r.be;
        vdata_wdata_i = {r.wdata, ~r.wdata};
        sdata_req_i   = 1'b1;  // competing scalar load
        sdata_addr_i  = r.addr + 32'h100;
        sdata_we_i    = 1'b0;
        @(negedge clk_i);
        require(vdata_gnt_o && !sdata_gnt_o, "vector request did not win over the scalar one");
        compare_value("mem_addr_o", MemW'(mem_addr_o), MemW'(r.addr));
        compare_value("mem_we_o", MemW'(mem_we_o), MemW'(r.we));
        drive_step();
        vdata_req_i = 1'b0;
        sdata_req_i = 1'b0;
        @(negedge clk_i);
        if (r.we) begin
            await_flag(FMemValid, "memory answer to the vector store");
            require(!vdata_rvalid_o, "vector store produced a response");
        end else begin
            await_flag(FVdataValid, "vector response");
            compare_value("vdata_rdata_o", vdata_rdata_o, {r.exp + 32'd4, r.exp});
        end
        drive_step();
    endtask

    task automatic mixed_traffic(addr_t base);
        addr_t offs[5]    = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd20};
        logic  is_data[5] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        int    got;
        int    waited;
        got    = 0;
        waited = 0;
        fork
            begin
                for (int i = 0; i < 5; i++) begin
                    instr_req_i  = !is_data[i];
                    instr_addr_i = base + offs[i];
                    sdata_req_i  = is_data[i];
                    sdata_addr_i = base + offs[i];
                    sdata_we_i   = 1'b0;
                    @(negedge clk_i);
                    require(instr_gnt_o || sdata_gnt_o, "mixed traffic request not granted");
                    drive_step();
                end
                instr_req_i = 1'b0;
                sdata_req_i = 1'b0;
            end
            begin
                while (got < 5 && waited < 5 * MaxWait) begin
                    @(negedge clk_i);
                    waited++;
                    if (instr_rvalid_o || sdata_rvalid_o) begin
                        require(sdata_rvalid_o == is_data[got] && instr_rvalid_o != is_data[got],
                                "response appeared on the wrong rvalid output");
                        if (is_data[got]) begin
                            compare_value("sdata_rdata_o", MemW'(sdata_rdata_o),
                                          MemW'(32'hA500_0000 + base + offs[got]));
                        end else begin
                            compare_value("instr_rdata_o", MemW'(instr_rdata_o),
                                          MemW'(32'hA500_0000 + base + offs[got]));
                        end
                        got++;
                    end
                end
                require(got == 5, "mixed traffic lost responses");
            end
        join
        drive_step();
    endtask

    task automatic apply_row(row_t r);
        case (r.kind)
            KCsrWr: begin
                csr_addr_i  = r.addr[11:0];
                csr_wdata_i = r.wdata;
                csr_we_i    = 1'b1;
                drive_step();
                csr_we_i    = 1'b0;
            end
            KCsrRd: begin
                csr_addr_i = r.addr[11:0];
                @(negedge clk_i);
                compare_value("csr_rdata_o", MemW'(csr_rdata_o), MemW'(r.exp));
                case (r.addr[11:0])  // register outputs follow the same state
                    CsrVstart: compare_value("vstart_o", MemW'(vstart_o), MemW'(r.exp));
                    CsrVxsat:  compare_value("vxsat_o", MemW'(vxsat_o), MemW'(r.exp));
                    CsrVxrm:   compare_value("vxrm_o", MemW'(vxrm_o), MemW'(r.exp));
                    default: ;
                endcase
                drive_step();
            end
            KScalar: scalar_access(r);
            KVector: vector_access(r);
            default: mixed_traffic(r.addr);
        endcase
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        void'($urandom(31));
        rst_ni          = 1'b0;
        instr_req_i     = 1'b0;
        instr_addr_i    = '0;
        sdata_req_i     = 1'b0;
        sdata_addr_i    = '0;
        sdata_we_i      = 1'b0;
        sdata_be_i      = '0;
        sdata_wdata_i   = '0;
        vdata_req_i     = 1'b0;
        vdata_addr_i    = '0;
        vdata_we_i      = 1'b0;
        vdata_be_i      = '0;
        vdata_wdata_i   = '0;
        pending_load_i  = 1'b0;
        pending_store_i = 1'b0;
        mem_rvalid_i    = 1'b0;
        mem_err_i       = 1'b0;
        mem_rdata_i     = '0;
        csr_addr_i      = '0;
        csr_we_i        = 1'b0;
        csr_wdata_i     = '0;
        vl_i            = 32'd7;
        vtype_i         = 32'h0000_00D1;

        csr_row(KCsrRd, CsrVstart, 32'd0);
        csr_row(KCsrRd, CsrVxsat,  32'd0);
        csr_row(KCsrRd, CsrVxrm,   32'd0);
        csr_row(KCsrRd, CsrVcsr,   32'd0);
        csr_row(KCsrRd, CsrVlenb,  32'(VregW / 8));
        csr_row(KCsrWr, CsrVcsr,   32'd5);
        csr_row(KCsrRd, CsrVxrm,   32'd2);
        csr_row(KCsrRd, CsrVxsat,  32'd1);
        csr_row(KCsrWr, CsrVxrm,   32'd1);  // vcsr upper bits change
        csr_row(KCsrRd, CsrVcsr,   32'd3);
        csr_row(KCsrRd, CsrVxsat,  32'd1);
        csr_row(KCsrRd, CsrVl,     32'd7);
        csr_row(KCsrRd, CsrVtype,  32'h0000_00D1);
        csr_row(KCsrWr, CsrVstart, 32'd9);
        csr_row(KCsrRd, CsrVstart, 32'd9);
        //       kind     addr      we    wdata         be     pl    ps    exp           exp_be
        data_row(KScalar, 32'h104, 1'b1, 32'h12345678, 8'h03, 1'b0, 1'b0, 32'h00000000, 8'h30);
        data_row(KScalar, 32'h104, 1'b0, 32'h00000000, 8'h0F, 1'b0, 1'b0, 32'hA5000104, 8'h00);
        data_row(KScalar, 32'h108, 1'b0, 32'h00000000, 8'h0F, 1'b0, 1'b1, 32'hA5000108, 8'h00);
        data_row(KScalar, 32'h10C, 1'b1, 32'hCAFEF00D, 8'h0F, 1'b1, 1'b0, 32'h00000000, 8'hF0);
        data_row(KScalar, 32'h100, 1'b0, 32'h00000000, 8'h0F, 1'b0, 1'b0, 32'hA5000100, 8'h00);
        data_row(KVector, 32'h200, 1'b0, 32'h00000000, 8'hFF, 1'b0, 1'b0, 32'hA5000200, 8'h00);
        data_row(KVector, 32'h208, 1'b1, 32'h5A5A0F0F, 8'hFF, 1'b0, 1'b0, 32'h00000000, 8'h00);
        data_row(KMix,    32'h400, 1'b0, 32'h00000000, 8'h00, 1'b0, 1'b0, 32'h00000000, 8'h00);

        repeat (4) @(posedge clk_i);
        #DriveDly;
        rst_ni = 1'b1;
        @(negedge clk_i);
        require(!mem_req_o, "mem_req_o high after reset");
        require(!instr_rvalid_o && !sdata_rvalid_o && !vdata_rvalid_o, "rvalid high after reset");
        drive_step();

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog, 20 cycles per table row
    initial begin
        #1;
        repeat (rows.size() * 20) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", rows.size() * 20);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/vbus_pkg.sv
logic/vbus_csr_bank.sv
logic/vbus_data_arbiter.sv
logic/vbus_mem_arbiter.sv
logic/vbus_top.sv
testbench/vbus_assert.sv
testbench/tb_vbus_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vector bus testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_vbus_top \
    -Mdir "$BUILD_DIR" -o sim_vbus
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./"$BUILD_DIR"/sim_vbus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -- "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0
